// File: sim/dcache_input.txt
# test op addr wdata byte_enables pipe_ready_low_cycles expected_read
# writes carry 00000000 as their expected word.
read_fill read 00000100 00000000 f 0 5a5a0100
read_fill read 00000104 00000000 f 0 5a5a0104
read_fill read 0000011c 00000000 f 0 5a5a011c
read_fill read 00000100 00000000 f 0 5a5a0100
read_fill idle 00000000 00000000 0 0 00000000
write_merge write 00000108 deadbeef 3 0 00000000
write_merge read 00000108 00000000 f 0 5a5abeef
write_merge write 0000010c 11223344 8 0 00000000
write_merge read 0000010c 00000000 f 0 115a010c
lru read 00000020 00000000 f 0 5a5a0020
lru read 00001020 00000000 f 0 5a5a1020
lru read 00000020 00000000 f 0 5a5a0020
lru read 00002020 00000000 f 0 5a5a2020
lru read 00000020 00000000 f 0 5a5a0020
lru read 00001020 00000000 f 0 5a5a1020
lru idle 00000000 00000000 0 0 00000000
dirty_wb write 00000044 cafef00d f 0 00000000
dirty_wb read 00001040 00000000 f 0 5a5a1040
dirty_wb read 00002040 00000000 f 0 5a5a2040
dirty_wb read 00000044 00000000 f 0 cafef00d
dirty_wb read 00000040 00000000 f 0 5a5a0040
back_pressure read 00000104 00000000 f 3 5a5a0104
back_pressure read 00003000 00000000 f 4 5a5a3000
back_pressure read 00000108 00000000 f 2 5a5abeef
back_pressure idle 00000000 00000000 0 0 00000000
back_to_back read 00000100 00000000 f 0 5a5a0100
back_to_back read 00000104 00000000 f 0 5a5a0104
back_to_back read 0000011c 00000000 f 0 5a5a011c
back_to_back read 00003004 00000000 f 0 5a5a3004
back_to_back read 00000108 00000000 f 0 5a5abeef

// File: verilog.f
src/dcache_pkg.sv
src/dcache_ctrl_if.sv
src/dcache_control.sv
src/dcache_datapath.sv
src/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// File: sim/tb_dcache.sv
module tb_dcache;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst_n;
	logic cpu_read;
	logic cpu_write;
	dcache_pkg::addr_t cpu_addr;
	dcache_pkg::word_t cpu_wdata;
	dcache_pkg::be_t cpu_be;
	logic pipe_ready;
	dcache_pkg::word_t cpu_rdata;
	logic cpu_resp;
	logic pipe_run;
	dcache_pkg::addr_t pmem_addr;
	dcache_pkg::line_t pmem_wdata;
	logic pmem_read;
	logic pmem_write;
	dcache_pkg::line_t pmem_rdata;
	logic pmem_resp;
	int errors;

	string op_name [$];
	string op_kind [$];
	dcache_pkg::addr_t op_addr [$];
	dcache_pkg::word_t op_wdata [$];
	dcache_pkg::be_t op_be [$];
	int op_stall [$];
	dcache_pkg::word_t op_exp [$];
	int num_ops;
	bit loaded;
	bit s_resp;
	bit s_rdy;
	dcache_pkg::word_t mem [dcache_pkg::addr_t];

	dcache_top DUT (.*);

	dcache_checker u_checker (
		.clk (clk), .rst_n (rst_n), .cpu_resp (cpu_resp), .cpu_rdata (cpu_rdata),
		.pipe_ready (pipe_ready), .pipe_run (pipe_run), .pmem_read (pmem_read),
		.pmem_write (pmem_write), .pmem_resp (pmem_resp),
		.pmem_addr (pmem_addr), .pmem_wdata (pmem_wdata), .errors (errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
		return mem.exists(a) ? mem[a] : a ^ 32'h5a5a_0000;
	endfunction

	task automatic load_ops();
		int fd;
		string line;
		string name;
		string kind;
		dcache_pkg::addr_t addr;
		dcache_pkg::word_t wdata;
		dcache_pkg::be_t be;
		int stall;
		dcache_pkg::word_t exp;
		fd = $fopen("sim/dcache_input.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/dcache_input.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line[0] != "#") begin
					void'($sscanf(line, "%s %s %h %h %h %d %h",
						name, kind, addr, wdata, be, stall, exp));
					op_name.push_back(name);
					op_kind.push_back(kind);
					op_addr.push_back(addr);
					op_wdata.push_back(wdata);
					op_be.push_back(be);
					op_stall.push_back(stall);
					op_exp.push_back(exp);
				end
			end
			$fclose(fd);
			num_ops = op_name.size();
			loaded = 1'b1;
		end
	endtask

	// ====================
	// memory model
	// ====================

	initial begin
		int cnt;
		bit busy;
		void'($urandom(6));
		busy = 1'b0;
		cnt = 0;
		forever begin
			@(posedge clk);
			#5;
			pmem_resp = 1'b0;
			if (!busy && (pmem_read || pmem_write)) begin
				busy = 1'b1;
				cnt = $urandom_range(6, 2);
			end else if (busy) begin
				cnt--;
				if (cnt <= 1) begin
					for (int k = 0; k < dcache_pkg::words_per_line; k++) begin
						if (pmem_write) begin
							mem[pmem_addr + 4*k] = pmem_wdata[k*32 +: 32];
						end
						pmem_rdata[k*32 +: 32] = mem_word(pmem_addr + 4*k);
					end
					pmem_resp = 1'b1;
					busy = 1'b0;
				end
			end
		end
	end

	always @(negedge clk) begin
		s_resp = cpu_resp;
		s_rdy = pipe_ready;
	end

	initial begin
		wait (loaded);
		#(num_ops * 40 * 100);
		$display("watchdog expired before all requests completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ====================
	// stimulus
	// ====================

	initial begin
		int i;
		int hold_left;
		bit pending;
		bit presented;
		{cpu_read, cpu_write, cpu_addr, cpu_wdata, cpu_be} = '0;
		{pmem_rdata, pmem_resp} = '0;
		pipe_ready = 1'b1;
		rst_n = 1'b0;
		loaded = 1'b0;
		load_ops();
		repeat (10) @(posedge clk);
		#5 rst_n = 1'b1;
		i = 0;
		hold_left = 0;
		pending = 1'b0;
		presented = 1'b0;
		while (i < num_ops || pending) begin
			@(posedge clk);
			#5;
			if (pending && s_resp && !s_rdy && hold_left > 0) begin
				hold_left--;
			end
			if (pending && s_resp && s_rdy) begin
				pending = 1'b0;
			end
			if (presented && !pending) begin
				u_checker.expect_op(op_name[i], op_addr[i], op_wdata[i], op_be[i],
					op_kind[i] == "write", op_exp[i]);
				pending = 1'b1;
				hold_left = op_stall[i];
				i++;
			end
			presented = 1'b0;
			cpu_read = 1'b0;
			cpu_write = 1'b0;
			if (i < num_ops) begin
				if (op_kind[i] == "idle") begin
					i++;
				end else begin
					cpu_read = op_kind[i] == "read";
					cpu_write = op_kind[i] == "write";
					{cpu_addr, cpu_wdata, cpu_be} = {op_addr[i], op_wdata[i], op_be[i]};
					presented = 1'b1;
				end
			end
			pipe_ready = !(pending && hold_left > 0);
		end
		repeat (3) @(posedge clk);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: sim/dcache_checker.sv
module dcache_checker (
	input logic clk,
	input logic rst_n,
	input logic cpu_resp,
	input dcache_pkg::word_t cpu_rdata,
	input logic pipe_ready,
	input logic pipe_run,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input dcache_pkg::addr_t pmem_addr,
	input dcache_pkg::line_t pmem_wdata,
	output int errors
);

	timeunit 1ns;
	timeprecision 1ps;

	dcache_pkg::word_t shadow [dcache_pkg::addr_t];

	// outstanding requests, oldest first.
	string q_name [$];
	dcache_pkg::addr_t q_addr [$];
	dcache_pkg::word_t q_wdata [$];
	dcache_pkg::be_t q_be [$];
	bit q_write [$];
	dcache_pkg::word_t q_exp [$];

	// the checker keeps its own tags of both ways to know which requests must miss.
	dcache_pkg::tag_t m_tag [2][dcache_pkg::num_sets];
	bit m_valid [2][dcache_pkg::num_sets];
	bit m_dirty [2][dcache_pkg::num_sets];
	bit m_lru [dcache_pkg::num_sets];

	// memory traffic seen for the oldest request.
	bit filled;
	bit wrote_back;

	bit held;
	dcache_pkg::word_t held_word;

	initial begin
		errors = 0;
		held = 1'b0;
		held_word = '0;
		filled = 1'b0;
		wrote_back = 1'b0;
	end

	function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t addr);
		dcache_pkg::addr_t a;
		a = {addr[31:2], 2'b00};
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ 32'h5a5a_0000;
	endfunction

	function automatic dcache_pkg::addr_t line_base(input dcache_pkg::addr_t addr);
		return {addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
			{dcache_pkg::offset_w{1'b0}}};
	endfunction

	function automatic dcache_pkg::index_t set_of(input dcache_pkg::addr_t addr);
		return addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
	endfunction

	// way that holds the line of addr, or -1 when the line is not cached.
	function automatic int cached_way(input dcache_pkg::addr_t addr);
		dcache_pkg::index_t s;
		s = set_of(addr);
		for (int w = 0; w < 2; w++) begin
			if (m_valid[w][s] && m_tag[w][s] == addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w])
			begin
				return w;
			end
		end
		return -1;
	endfunction

	task automatic expect_op(input string name, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t wdata, input dcache_pkg::be_t be, input bit write,
		input dcache_pkg::word_t exp);
		q_name.push_back(name);
		q_addr.push_back(addr);
		q_wdata.push_back(wdata);
		q_be.push_back(be);
		q_write.push_back(write);
		q_exp.push_back(exp);
	endtask

	task automatic apply_write(input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
		input dcache_pkg::be_t be);
		dcache_pkg::word_t w;
		w = shadow_word(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				w[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		shadow[{addr[31:2], 2'b00}] = w;
	endtask

	// checks the fills and write-backs of a finished request against the tags
	// and then replaces lines by LRU.
	task automatic track_line(input string name, input dcache_pkg::addr_t addr, input bit write);
		dcache_pkg::index_t s;
		int w;
		bit miss;
		bit exp_wb;
		s = set_of(addr);
		w = cached_way(addr);
		miss = (w < 0);
		exp_wb = miss && m_valid[m_lru[s]][s] && m_dirty[m_lru[s]][s];
		if (filled !== miss) begin
			errors++;
			$display("ERROR %s: expected line fill %0b, actual %0b", name, miss, filled);
		end
		if (wrote_back !== exp_wb) begin
			errors++;
			$display("ERROR %s: expected write-back %0b, actual %0b", name, exp_wb, wrote_back);
		end
		if (miss) begin
			w = m_lru[s];
			m_tag[w][s] = addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
			m_valid[w][s] = 1'b1;
			m_dirty[w][s] = 1'b0;
		end
		if (write) begin
			m_dirty[w][s] = 1'b1;
		end
		m_lru[s] = (w == 0);
		filled = 1'b0;
		wrote_back = 1'b0;
	endtask

	// ====================
	// response checks
	// ====================

	always @(negedge clk) begin
		dcache_pkg::line_t exp_line;
		dcache_pkg::word_t exp_word;
		dcache_pkg::addr_t exp_addr;
		dcache_pkg::index_t s;
		bit v;
		if (rst_n && pmem_write && pmem_resp) begin
			if (q_name.size() == 0) begin
				errors++;
				$display("a write-back finished with no request outstanding");
			end else begin
				s = set_of(q_addr[0]);
				v = m_lru[s];
				exp_addr = {m_tag[v][s], s, {dcache_pkg::offset_w{1'b0}}};
				wrote_back = 1'b1;
				if (pmem_addr !== exp_addr) begin
					errors++;
					$display("ERROR %s: expected write-back address %h, actual %h",
						q_name[0], exp_addr, pmem_addr);
				end
				// a write-back must carry the line as the processor last wrote it.
				for (int k = 0; k < dcache_pkg::words_per_line; k++) begin
					exp_line[k*32 +: 32] = shadow_word(exp_addr + 4*k);
				end
				if (pmem_wdata !== exp_line) begin
					errors++;
					$display("ERROR %s: expected write-back data %h, actual %h",
						q_name[0], exp_line, pmem_wdata);
				end
			end
		end
		if (rst_n && pmem_read && pmem_resp) begin
			if (q_name.size() == 0) begin
				errors++;
				$display("a line fill finished with no request outstanding");
			end else begin
				filled = 1'b1;
				exp_addr = line_base(q_addr[0]);
				if (pmem_addr !== exp_addr) begin
					errors++;
					$display("ERROR %s: expected fill address %h, actual %h",
						q_name[0], exp_addr, pmem_addr);
				end
			end
		end
		if (rst_n && cpu_resp && !pipe_run) begin
			errors++;
			$display("pipe_run was low during a response");
		end
		if (rst_n && (pmem_read || pmem_write) && !cpu_resp && pipe_run) begin
			errors++;
			$display("pipe_run stayed high while the cache waited on memory");
		end
		if (rst_n && cpu_resp) begin
			if (q_name.size() == 0) begin
				errors++;
				$display("cpu_resp was raised with no request outstanding");
			end else begin
				if (!q_write[0]) begin
					exp_word = shadow_word(q_addr[0]);
					if (cpu_rdata !== exp_word) begin
						errors++;
						$display("ERROR %s: expected %h, actual %h", q_name[0], exp_word, cpu_rdata);
					end
					if (cpu_rdata !== q_exp[0]) begin
						errors++;
						$display("ERROR %s: expected %h from the data file, actual %h",
							q_name[0], q_exp[0], cpu_rdata);
					end
					if (held && cpu_rdata !== held_word) begin
						errors++;
						$display("read data changed while the response was held in %s", q_name[0]);
					end
				end
				if (pipe_ready) begin
					track_line(q_name[0], q_addr[0], q_write[0]);
					if (q_write[0]) begin
						apply_write(q_addr[0], q_wdata[0], q_be[0]);
					end
					void'(q_name.pop_front());
					void'(q_addr.pop_front());
					void'(q_wdata.pop_front());
					void'(q_be.pop_front());
					void'(q_write.pop_front());
					void'(q_exp.pop_front());
					held = 1'b0;
				end else begin
					held = 1'b1;
					held_word = cpu_rdata;
				end
			end
		end
	end

endmodule

// File: src/dcache_top.sv
module dcache_top (
	input logic clk,
	input logic rst_n,

	// processor side.
	input logic cpu_read,
	input logic cpu_write,
	input dcache_pkg::addr_t cpu_addr,
	input dcache_pkg::word_t cpu_wdata,
	input dcache_pkg::be_t cpu_be,
	input logic pipe_ready,
	output dcache_pkg::word_t cpu_rdata,
	output logic cpu_resp,
	output logic pipe_run,

	// memory side.
	output dcache_pkg::addr_t pmem_addr,
	output dcache_pkg::line_t pmem_wdata,
	output logic pmem_read,
	output logic pmem_write,
	input dcache_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	dcache_ctrl_if ctl_bus ();

	dcache_control u_control (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_read (cpu_read),
		.cpu_write (cpu_write),
		.pipe_ready (pipe_ready),
		.pmem_resp (pmem_resp),
		.cpu_resp (cpu_resp),
		.pipe_run (pipe_run),
		.ctl (ctl_bus.ctrl)
	);

	dcache_datapath u_datapath (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_addr (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_be (cpu_be),
		.cpu_write (cpu_write),
		.pmem_rdata (pmem_rdata),
		.cpu_rdata (cpu_rdata),
		.pmem_addr (pmem_addr),
		.pmem_wdata (pmem_wdata),
		.dp (ctl_bus.dp)
	);

	// the memory levels come from the controller.
	assign pmem_read = ctl_bus.pmem_read;
	assign pmem_write = ctl_bus.pmem_write;

endmodule

// File: src/dcache_datapath.sv
module dcache_datapath (
	input logic clk,
	input logic rst_n,
	input dcache_pkg::addr_t cpu_addr,
	input dcache_pkg::word_t cpu_wdata,
	input dcache_pkg::be_t cpu_be,
	input logic cpu_write,
	input dcache_pkg::line_t pmem_rdata,
	output dcache_pkg::word_t cpu_rdata,
	output dcache_pkg::addr_t pmem_addr,
	output dcache_pkg::line_t pmem_wdata,
	dcache_ctrl_if.dp dp
);

	dcache_pkg::addr_t req_addr;
	dcache_pkg::word_t req_wdata;
	dcache_pkg::be_t req_be;
	logic req_write_q;

	dcache_pkg::tag_t [1:0][dcache_pkg::num_sets-1:0] tag_q;
	logic [1:0][dcache_pkg::num_sets-1:0] valid_q;
	logic [1:0][dcache_pkg::num_sets-1:0] dirty_q;
	logic [dcache_pkg::num_sets-1:0] lru_q;
	dcache_pkg::line_t line_q [2][dcache_pkg::num_sets];

	dcache_pkg::tag_t req_tag;
	dcache_pkg::index_t req_index;
	logic [dcache_pkg::offset_w-3:0] req_word;
	logic [1:0] way_hit;
	logic used_way;
	dcache_pkg::line_t base_line;
	dcache_pkg::line_t wr_line;
	dcache_pkg::word_t rd_word;
	dcache_pkg::word_t rdata_q;

	// byte merge of one word into a line.
	function automatic dcache_pkg::line_t merge_word(
		input dcache_pkg::line_t line,
		input dcache_pkg::word_t data,
		input dcache_pkg::be_t be,
		input logic [dcache_pkg::offset_w-3:0] sel
	);
		dcache_pkg::line_t merged;
		merged = line;
		for (int b = 0; b < $bits(dcache_pkg::be_t); b++) begin
			if (be[b]) begin
				merged[sel*$bits(dcache_pkg::word_t) + b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// ====================
	// request register
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_write_q <= 1'b0;
		end else if (dp.accept) begin
			req_write_q <= cpu_write;
		end
	end

	always_ff @(posedge clk) begin
		if (dp.accept) begin
			req_addr <= cpu_addr;
			req_wdata <= cpu_wdata;
			req_be <= cpu_be;
		end
	end

	assign req_tag = req_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
	assign req_index = req_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
	assign req_word = req_addr[dcache_pkg::offset_w-1:2];

	// ====================
	// lookup
	// ====================

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][req_index] && (tag_q[w][req_index] == req_tag);
		end
	end

	assign dp.way_hit = way_hit;
	assign dp.hit = |way_hit;
	assign dp.req_write = req_write_q;
	assign dp.lru_way = lru_q[req_index];
	assign dp.victim_dirty = valid_q[dp.lru_way][req_index] & dirty_q[dp.lru_way][req_index];

	// on a miss the line comes straight from memory.
	assign base_line = dp.hit ? line_q[way_hit[1]][req_index] : pmem_rdata;
	assign wr_line = req_write_q ? merge_word(base_line, req_wdata, req_be, req_word) : base_line;
	assign rd_word = base_line[req_word*$bits(dcache_pkg::word_t) +: $bits(dcache_pkg::word_t)];
	assign used_way = dp.hit ? way_hit[1] : dp.lru_way;

	always_ff @(posedge clk) begin
		if (dp.set_rdata) begin
			rdata_q <= rd_word;
		end
	end

	assign cpu_rdata = dp.read_rdata ? rdata_q : rd_word;

	// ====================
	// storage
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_q <= '0;
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (dp.load_tag[w]) begin
					tag_q[w][req_index] <= req_tag;
				end
				if (dp.set_valid[w]) begin
					valid_q[w][req_index] <= 1'b1;
				end
				if (dp.clear_dirty[w]) begin
					dirty_q[w][req_index] <= 1'b0;
				end
				if (dp.set_dirty[w]) begin
					dirty_q[w][req_index] <= 1'b1;
				end
			end
			// lru points at the way that was not used.
			if (dp.load_lru) begin
				lru_q[req_index] <= ~used_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (dp.load_data[w]) begin
				line_q[w][req_index] <= wr_line;
			end
		end
	end

	// write-back addresses the victim, everything else the request's line.
	assign pmem_wdata = line_q[dp.lru_way][req_index];
	assign pmem_addr = dp.pmem_write ?
		{tag_q[dp.lru_way][req_index], req_index, {dcache_pkg::offset_w{1'b0}}} :
		{req_tag, req_index, {dcache_pkg::offset_w{1'b0}}};

endmodule

// File: src/dcache_control.sv
module dcache_control (
	input logic clk,
	input logic rst_n,
	input logic cpu_read,
	input logic cpu_write,
	input logic pipe_ready,
	input logic pmem_resp,
	output logic cpu_resp,
	output logic pipe_run,
	dcache_ctrl_if.ctrl ctl
);

	typedef enum logic [2:0] {
		idle,
		hit_check,
		fill,
		write_back,
		hold_rdata
	} dcache_state_t;

	dcache_state_t state;
	dcache_state_t next_state;
	dcache_state_t after_resp;

	logic request;
	logic [1:0] lru_sel;

	// in a response cycle the processor inputs already carry the next request.
	assign request = cpu_read | cpu_write;

	// one-hot select of the way that gets replaced.
	assign lru_sel = {ctl.lru_way, ~ctl.lru_way};

	assign after_resp = !pipe_ready ? hold_rdata : (request ? hit_check : idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// ====================
	// next state
	// ====================

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (request) begin
					next_state = hit_check;
				end
			end
			hit_check: begin
				if (ctl.hit) begin
					next_state = after_resp;
				end else if (ctl.victim_dirty) begin
					next_state = write_back;
				end else begin
					next_state = fill;
				end
			end
			write_back: begin
				if (pmem_resp) begin
					next_state = fill;
				end
			end
			fill: begin
				if (pmem_resp) begin
					next_state = after_resp;
				end
			end
			hold_rdata: begin
				next_state = after_resp;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	// ====================
	// commands
	// ====================

	always_comb begin
		ctl.accept = 1'b0;
		ctl.load_data = 2'b00;
		ctl.load_tag = 2'b00;
		ctl.set_valid = 2'b00;
		ctl.set_dirty = 2'b00;
		ctl.clear_dirty = 2'b00;
		ctl.load_lru = 1'b0;
		ctl.set_rdata = 1'b0;
		ctl.read_rdata = 1'b0;
		ctl.pmem_read = 1'b0;
		ctl.pmem_write = 1'b0;
		cpu_resp = 1'b0;
		pipe_run = 1'b1;

		case (state)
			idle: begin
				ctl.accept = request;
			end
			hit_check: begin
				if (ctl.hit) begin
					cpu_resp = 1'b1;
					ctl.load_lru = 1'b1;
					ctl.set_rdata = ~pipe_ready;
					ctl.accept = request & pipe_ready;
					if (ctl.req_write) begin
						ctl.load_data = ctl.way_hit;
						ctl.set_dirty = ctl.way_hit;
					end
				end else begin
					pipe_run = 1'b0;
				end
			end
			write_back: begin
				// the victim is clean once memory has taken it.
				pipe_run = 1'b0;
				ctl.pmem_write = 1'b1;
				if (pmem_resp) begin
					ctl.clear_dirty = lru_sel;
				end
			end
			fill: begin
				ctl.pmem_read = 1'b1;
				if (pmem_resp) begin
					ctl.load_data = lru_sel;
					ctl.load_tag = lru_sel;
					ctl.set_valid = lru_sel;
					ctl.load_lru = 1'b1;
					ctl.set_rdata = 1'b1;
					ctl.accept = request & pipe_ready;
					cpu_resp = 1'b1;
					if (ctl.req_write) begin
						ctl.set_dirty = lru_sel;
					end
				end else begin
					pipe_run = 1'b0;
				end
			end
			hold_rdata: begin
				cpu_resp = 1'b1;
				ctl.read_rdata = 1'b1;
				ctl.accept = request & pipe_ready;
			end
			default: begin
				pipe_run = 1'b1;
			end
		endcase
	end

endmodule

// File: src/dcache_ctrl_if.sv
interface dcache_ctrl_if;

	// commands from the controller.
	logic accept;
	logic [1:0] load_data;
	logic [1:0] load_tag;
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	logic load_lru;
	logic set_rdata;
	logic read_rdata;
	logic pmem_read;
	logic pmem_write;

	// status from the datapath, all for the registered request.
	logic hit;
	logic [1:0] way_hit;
	logic victim_dirty;
	logic lru_way;
	logic req_write;

	modport ctrl (
		output accept, load_data, load_tag,
		output set_valid, set_dirty, clear_dirty,
		output load_lru, set_rdata, read_rdata,
		output pmem_read, pmem_write,
		input hit, way_hit, victim_dirty, lru_way, req_write
	);

	// the memory read level goes to the top level only.
	modport dp (
		input accept, load_data, load_tag,
		input set_valid, set_dirty, clear_dirty,
		input load_lru, set_rdata, read_rdata,
		input pmem_write,
		output hit, way_hit, victim_dirty, lru_way, req_write
	);

endinterface

// File: src/dcache_pkg.sv
package dcache_pkg;

	// ====================
	// cache geometry
	// ====================

	localparam int addr_w = 32;

	// a line holds 32 bytes, and the cache has 8 sets of two ways.
	localparam int offset_w = 5;
	localparam int index_w = 3;
	localparam int tag_w = addr_w - index_w - offset_w;

	localparam int num_sets = 8;
	localparam int words_per_line = 8;

	// ====================
	// types
	// ====================

	typedef logic [addr_w-1:0] addr_t;

	typedef logic [31:0] word_t;

	// one enable bit per byte of a word.
	typedef logic [3:0] be_t;

	typedef logic [words_per_line*$bits(word_t)-1:0] line_t;

	typedef logic [tag_w-1:0] tag_t;

	typedef logic [index_w-1:0] index_t;

endpackage
